//--- sim.f
design/seg_video_pkg.sv
design/video_timing.sv
design/digit_store.sv
design/seven_segment_decoder.sv
design/glyph_renderer.sv
design/seg_display_top.sv
test/tb_seg_display.sv

//--- test/tb_seg_display.sv
`timescale 1ns/100ps

module tb_seg_display;

  import seg_video_pkg::*;

  // small frame so a full run stays short
  localparam int H_ACTIVE = 256;
  localparam int H_FRONT  = 8;
  localparam int H_SYNC   = 16;
  localparam int H_BACK   = 8;
  localparam int V_ACTIVE = 40;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;

  localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
  localparam int RUN_CYCLES     = 3 * FRAME_CYCLES;
  localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 100;
  localparam int RESET_CYCLES   = 8;

  // digits that light each lamp, bit n set for digit n
  localparam logic [15:0] TOP_DIGITS    = 16'h03ED;
  localparam logic [15:0] UR_DIGITS     = 16'h039F;
  localparam logic [15:0] LR_DIGITS     = 16'h03FB;
  localparam logic [15:0] BOTTOM_DIGITS = 16'h036D;
  localparam logic [15:0] LL_DIGITS     = 16'h0145;
  localparam logic [15:0] UL_DIGITS     = 16'h0371;
  localparam logic [15:0] MIDDLE_DIGITS = 16'h037C;

  // one expected sample of the video pins
  typedef struct packed {
    rgb_t rgb;
    logic hsync;
    logic vsync;
  } video_out_t;

  logic        clk;
  logic        rst_n;
  logic        wr_en;
  digit_addr_t wr_addr;
  digit_t      wr_digit;
  logic        hsync;
  logic        vsync;
  rgb_t        rgb;

  integer     seed;
  int         cycle_count;
  int         model_h;
  int         model_v;
  int         write_count;
  int         lit_count;
  digit_t     mirror [16];
  video_out_t delay_line [2];
  video_out_t cur_out;
  video_out_t exp_out;

  seg_display_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_digit (wr_digit),
    .hsync    (hsync),
    .vsync    (vsync),
    .rgb      (rgb)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------

  // col 0 is the leftmost glyph pixel, line 0 the top line
  function automatic logic glyph_pixel(digit_t d, int col, int line);
    logic left;
    logic right;
    logic pix;
    left  = (col == 0);
    right = (col == 4);
    case (line)
      0: pix = TOP_DIGITS[d] ^ (right & UR_DIGITS[d]) ^ (left & UL_DIGITS[d]);
      1: pix = (left & UL_DIGITS[d]) | (right & UR_DIGITS[d]);
      2: pix = MIDDLE_DIGITS[d] ^ (right & (UR_DIGITS[d] | LR_DIGITS[d]))
               ^ (left & (UL_DIGITS[d] | LL_DIGITS[d]));
      3: pix = (left & LL_DIGITS[d]) | (right & LR_DIGITS[d]);
      4: pix = BOTTOM_DIGITS[d] ^ (right & LR_DIGITS[d]) ^ (left & LL_DIGITS[d]);
      default: pix = 1'b0;
    endcase
    return pix;
  endfunction

  // pins for beam position (h, v) with the store as it is now
  function automatic video_out_t model_output(int h, int v);
    video_out_t o;
    int         xofs;
    int         yofs;
    digit_t     d;
    xofs  = (h >> 1) & 7;
    yofs  = (v >> 1) & 7;
    d     = mirror[(h >> 4) & 15];
    o.rgb = '0;
    if ((h < H_ACTIVE) && (v < V_ACTIVE) && (xofs >= 3)) begin
      o.rgb[1] = glyph_pixel(d, xofs - 3, yofs);
    end
    o.hsync = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
    o.vsync = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
    return o;
  endfunction

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  task automatic compare_rgb(rgb_t got, rgb_t expected);
    if (got !== expected) begin
      $display("Error: rgb is %h, expected %h at beam %0d,%0d", got, expected,
               model_h, model_v);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // sync pair as {hsync, vsync}
  task automatic compare_sync(logic [1:0] got, logic [1:0] expected);
    if (got !== expected) begin
      $display("Error: {hsync,vsync} is %h, expected %h at beam %0d,%0d", got,
               expected, model_h, model_v);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1);
    end
  end

  // --------------------------------------------------------------------
  // stimulus and run
  // --------------------------------------------------------------------

  initial begin
    seed        = 24;
    cycle_count = 0;
    model_h     = 0;
    model_v     = 0;
    write_count = 0;
    lit_count   = 0;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_digit    = '0;
    for (int i = 0; i < 16; i++) begin
      mirror[i] = '0;
    end
    delay_line[0] = '0;
    delay_line[1] = '0;

    // outputs held at zero through reset
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      compare_rgb(rgb, '0);
      compare_sync({hsync, vsync}, 2'b00);
    end

    for (int j = 0; j < RUN_CYCLES; j++) begin
      @(posedge clk);
      if (j == 0) begin
        // last edge in reset, counters start from here
        rst_n <= 1'b1;
      end else if (wr_en) begin
        mirror[wr_addr] = wr_digit;
        write_count++;
      end

      cur_out       = model_output(model_h, model_v);
      exp_out       = delay_line[1];
      delay_line[1] = delay_line[0];
      delay_line[0] = cur_out;

      wr_en    <= (($random(seed) & 7) == 0);
      wr_addr  <= digit_addr_t'($random(seed));
      wr_digit <= digit_t'($random(seed));

      // step the model beam
      if (model_h == H_TOTAL - 1) begin
        model_h = 0;
        if (model_v == V_TOTAL - 1) begin
          model_v = 0;
        end else begin
          model_v++;
        end
      end else begin
        model_h++;
      end

      @(negedge clk);
      compare_rgb(rgb, exp_out.rgb);
      compare_sync({hsync, vsync}, {exp_out.hsync, exp_out.vsync});
      if (exp_out.rgb[1]) begin
        lit_count++;
      end
    end

    $display("%0d digit writes, %0d lit pixels compared", write_count, lit_count);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- design/seg_display_top.sv
`timescale 1ns/100ps

module seg_display_top #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  seg_video_pkg::digit_addr_t wr_addr,
  input  seg_video_pkg::digit_t      wr_digit,
  output logic                       hsync,
  output logic                       vsync,
  output seg_video_pkg::rgb_t        rgb
);

  import seg_video_pkg::*;

  beam_t       beam;
  digit_addr_t rd_addr;
  digit_t      rd_digit;

  // --------------------------------------------------------------------
  // raster timing
  // --------------------------------------------------------------------

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .beam  (beam)
  );

  // --------------------------------------------------------------------
  // digit storage and rendering
  // --------------------------------------------------------------------

  digit_store u_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_digit (wr_digit),
    .rd_addr  (rd_addr),
    .rd_digit (rd_digit)
  );

  // two cycles from beam to pins
  glyph_renderer u_renderer (
    .clk      (clk),
    .rst_n    (rst_n),
    .beam     (beam),
    .rd_addr  (rd_addr),
    .rd_digit (rd_digit),
    .hsync    (hsync),
    .vsync    (vsync),
    .rgb      (rgb)
  );

endmodule

//--- design/glyph_renderer.sv
`timescale 1ns/100ps

module glyph_renderer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  seg_video_pkg::beam_t       beam,
  output seg_video_pkg::digit_addr_t rd_addr,
  input  seg_video_pkg::digit_t      rd_digit,
  output logic                       hsync,
  output logic                       vsync,
  output seg_video_pkg::rgb_t        rgb
);

  import seg_video_pkg::*;

  // one glyph line from the lamp set, built by XOR of strokes
  function automatic glyph_row_t segment_row(segments_t seg, logic [2:0] line);
    glyph_row_t row;
    case (line)
      3'd0: row = {5{seg[6]}} ^ {4'b0000, seg[5]} ^ {seg[1], 4'b0000};
      3'd1: row = {seg[1], 3'b000, seg[5]};
      3'd2: row = {5{seg[0]}} ^ {4'b0000, |seg[5:4]} ^ {|seg[2:1], 4'b0000};
      3'd3: row = {seg[2], 3'b000, seg[4]};
      3'd4: row = {5{seg[3]}} ^ {4'b0000, seg[4]} ^ {seg[2], 4'b0000};
      default: row = '0;
    endcase
    return row;
  endfunction

  segments_t  segments;
  beam_t      s1_beam;
  segments_t  s1_segments;
  logic [2:0] xofs;
  logic [2:0] yofs;
  glyph_row_t row_bits;
  logic [7:0] cell_line;
  logic       green;

  // --------------------------------------------------------------------
  // stage 1: look up and decode the digit under the beam
  // --------------------------------------------------------------------

  // 16 pixels per cell, so hpos bits 7:4 pick the column
  assign rd_addr = beam.hpos[7:4];

  seven_segment_decoder u_decoder (
    .digit    (rd_digit),
    .segments (segments)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_beam <= '0;
    end else begin
      s1_beam <= beam;
    end
  end

  always_ff @(posedge clk) begin
    s1_segments <= segments;
  end

  // --------------------------------------------------------------------
  // stage 2: glyph line and pixel select
  // --------------------------------------------------------------------

  // doubled pixels, so drop bit 0 of each offset
  assign xofs = s1_beam.hpos[3:1];
  assign yofs = s1_beam.vpos[3:1];

  assign row_bits = segment_row(s1_segments, yofs);

  // glyph sits in columns 3 to 7 of the cell, ~xofs lands on the right bit
  assign cell_line = {3'b000, row_bits};

  assign green = s1_beam.display_on && (xofs >= 3'd3) && cell_line[~xofs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end else begin
      hsync <= s1_beam.hsync;
      vsync <= s1_beam.vsync;
      rgb   <= {1'b0, green, 1'b0};
    end
  end

  // nothing lit when the beam two cycles back was in blanking
  a_dark_in_blank : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$past(beam.display_on, 2) |-> (rgb == '0)
  ) else $error("pixel lit during blanking");

endmodule

//--- design/seven_segment_decoder.sv
`timescale 1ns/100ps

module seven_segment_decoder (
  input  seg_video_pkg::digit_t    digit,
  output seg_video_pkg::segments_t segments
);

  // lamp order, msb first
  //   top, upper right, lower right, bottom, lower left, upper left, middle
  always_comb begin
    case (digit)
      4'd0:    segments = 7'b1111110;
      4'd1:    segments = 7'b0110000;
      4'd2:    segments = 7'b1101101;
      4'd3:    segments = 7'b1111001;
      4'd4:    segments = 7'b0110011;
      4'd5:    segments = 7'b1011011;
      4'd6:    segments = 7'b1011111;
      4'd7:    segments = 7'b1110000;
      4'd8:    segments = 7'b1111111;
      4'd9:    segments = 7'b1111011;
      // codes 10 to 15 stay dark
      default: segments = 7'b0000000;
    endcase
  end

endmodule

//--- design/digit_store.sv
`timescale 1ns/100ps

module digit_store (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  seg_video_pkg::digit_addr_t wr_addr,
  input  seg_video_pkg::digit_t      wr_digit,
  input  seg_video_pkg::digit_addr_t rd_addr,
  output seg_video_pkg::digit_t      rd_digit
);

  import seg_video_pkg::*;

  // one entry per digit column
  localparam int DEPTH = 2 ** $bits(digit_addr_t);

  digit_t digits [DEPTH];

  // --------------------------------------------------------------------
  // write port
  // --------------------------------------------------------------------

  // all digits read as 0 after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        digits[i] <= '0;
      end
    end else if (wr_en) begin
      digits[wr_addr] <= wr_digit;
    end
  end

  // --------------------------------------------------------------------
  // read port
  // --------------------------------------------------------------------

  // same-cycle read returns the old value, the write lands at the edge
  assign rd_digit = digits[rd_addr];

  a_write_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown({wr_addr, wr_digit})
  ) else $error("digit write with unknown address or data");

endmodule

//--- design/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output seg_video_pkg::beam_t beam
);

  import seg_video_pkg::*;

  // --------------------------------------------------------------------
  // region boundaries
  // --------------------------------------------------------------------

  localparam pos_t H_ACT_END    = pos_t'(H_ACTIVE);
  localparam pos_t H_SYNC_START = pos_t'(H_ACTIVE + H_FRONT);
  localparam pos_t H_SYNC_END   = pos_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam pos_t H_LAST       = pos_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

  localparam pos_t V_ACT_END    = pos_t'(V_ACTIVE);
  localparam pos_t V_SYNC_START = pos_t'(V_ACTIVE + V_FRONT);
  localparam pos_t V_SYNC_END   = pos_t'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam pos_t V_LAST       = pos_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

  pos_t hcount;
  pos_t vcount;
  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (hcount == H_LAST);
  assign v_wrap = (vcount == V_LAST);

  // --------------------------------------------------------------------
  // raster counters
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
    end else if (h_wrap) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // line count advances once per horizontal wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vcount <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 1'b1;
      end
    end
  end

  // beam is straight from the counters, no register stage here
  always_comb begin
    beam.hpos       = hcount;
    beam.vpos       = vcount;
    beam.display_on = (hcount < H_ACT_END) && (vcount < V_ACT_END);
    beam.hsync      = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
    beam.vsync      = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
  end

  // sync must sit entirely in the blanking interval
  a_hsync_in_blank : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(beam.hsync && beam.display_on)
  ) else $error("hsync asserted inside the active window");

endmodule

//--- design/seg_video_pkg.sv
// shared types for the seven-segment video display

package seg_video_pkg;

  // --------------------------------------------------------------------
  // plain vector types
  // --------------------------------------------------------------------

  // beam coordinate, pixels or lines
  typedef logic [9:0] pos_t;

  // digit code, 0 to 9 drawn, 10 to 15 blank
  typedef logic [3:0] digit_t;

  // digit column index into the store
  typedef logic [3:0] digit_addr_t;

  // segment lamps
  // bit 6 top, 5 upper right, 4 lower right, 3 bottom,
  // 2 lower left, 1 upper left, 0 middle
  typedef logic [6:0] segments_t;

  // one line of the 5x5 glyph, bit 4 is the leftmost pixel
  typedef logic [4:0] glyph_row_t;

  // {blue, green, red}
  typedef logic [2:0] rgb_t;

  // --------------------------------------------------------------------
  // beam state from the timing generator
  // --------------------------------------------------------------------

  // 23 bits in all
  typedef struct packed {
    pos_t hpos;
    pos_t vpos;
    logic display_on;
    logic hsync;
    logic vsync;
  } beam_t;

endpackage
